//--- Makefile
# Verilator build and run for the VGA controller testbench

VERILATOR ?= verilator
TOP       ?= tb_vga_master
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

check:
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/vga_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module vga_fetch #(
  parameter int DEPTH = 16
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire vga_pkg::fb_adr_t base_i,
  input  wire                   frame_start_i,
  input  wire                   pop_i,
  input  wire                   fb_ack_i,
  input  wire                   fb_stall_i,
  input  wire vga_pkg::wb_dat_t fb_dat_i,
  output logic                  fb_cyc_o,
  output logic                  fb_stb_o,
  output vga_pkg::fb_adr_t      fb_adr_o,
  output vga_pkg::wb_dat_t      word_o,
  output logic                  empty_o
);

  import vga_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 2;

  wb_dat_t       mem [DEPTH];
  logic [AW:0]   wptr_q, rptr_q, count;
  logic [CW-1:0] pending_q, drop_q, pending_n, slots_used;
  fb_adr_t       adr_q;
  logic          stb_q, stale_q;
  logic          acc, push, full;

  assign acc   = stb_q && !fb_stall_i;
  assign count = wptr_q - rptr_q;
  assign full  = (count == (AW+1)'(DEPTH));
  // acks still owed from the previous frame are dropped
  assign push  = fb_ack_i && (drop_q == '0) && !frame_start_i;

  assign pending_n  = pending_q + CW'(acc) - CW'(fb_ack_i);
  assign slots_used = pending_q + CW'(count) + CW'(stb_q); // a waiting request holds a slot

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      stb_q     <= 1'b0;
      stale_q   <= 1'b0;
      adr_q     <= '0;
      pending_q <= '0;
      drop_q    <= '0;
      wptr_q    <= '0;
      rptr_q    <= '0;
    end
    else
    begin
      pending_q <= pending_n;
      stb_q     <= (stb_q && fb_stall_i) || (slots_used < CW'(DEPTH));
      if (frame_start_i)
      begin
        drop_q <= pending_n;
        wptr_q <= '0;
        rptr_q <= '0;
        if (stb_q && fb_stall_i)
          stale_q <= 1'b1; // keep the stalled request, drop its data later
        else
        begin
          stale_q <= 1'b0;
          adr_q   <= base_i;
        end
      end
      else
      begin
        drop_q <= drop_q + CW'(acc && stale_q) - CW'(fb_ack_i && drop_q != '0);
        if (push)
          wptr_q <= wptr_q + 1'b1;
        if (pop_i)
          rptr_q <= rptr_q + 1'b1;
        if (acc)
        begin
          adr_q   <= stale_q ? base_i : adr_q + 32'd1;
          stale_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wptr_q[AW-1:0]] <= fb_dat_i;
  end

  assign word_o   = mem[rptr_q[AW-1:0]]; // show-ahead
  assign empty_o  = (count == '0);
  assign fb_stb_o = stb_q;
  assign fb_adr_o = adr_q;
  assign fb_cyc_o = stb_q || (pending_q != '0);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    push |-> !full);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- hw/vga_master.sv
`timescale 1ns/1ps
`default_nettype none

module vga_master #(
  parameter int H_ACTIVE   = 640,
  parameter int H_FRONT    = 16,
  parameter int H_SYNC     = 96,
  parameter int H_BACK     = 48,
  parameter int V_ACTIVE   = 480,
  parameter int V_FRONT    = 10,
  parameter int V_SYNC     = 2,
  parameter int V_BACK     = 33,
  parameter int FIFO_DEPTH = 16
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  // register slave
  input  wire                   in_cyc_i,
  input  wire                   in_stb_i,
  input  wire                   in_we_i,
  input  wire vga_pkg::wb_adr_t in_adr_i,
  input  wire vga_pkg::wb_sel_t in_sel_i,
  input  wire vga_pkg::wb_dat_t in_dat_i,
  output logic                  in_ack_o,
  output logic                  in_stall_o,
  output vga_pkg::wb_dat_t      in_dat_o,
  // frame buffer read master
  output logic                  fb_cyc_o,
  output logic                  fb_stb_o,
  output vga_pkg::fb_adr_t      fb_adr_o,
  input  wire                   fb_ack_i,
  input  wire                   fb_stall_i,
  input  wire vga_pkg::wb_dat_t fb_dat_i,
  // video out
  output logic [7:0]            r_o,
  output logic [7:0]            g_o,
  output logic [7:0]            b_o,
  output logic                  hs_o,
  output logic                  vs_o,
  output logic                  blank_n_o
);

  import vga_pkg::*;

  fb_adr_t    base;
  vga_mode_t  mode;
  logic       pal_we;
  logic [7:0] pal_widx, cidx;
  rgb_t       pal_wdat, pal_rdat, cdat;
  logic       underrun, frame_start, pop, empty;
  wb_dat_t    word;
  logic       t_hs, t_vs, t_active;

  vga_regs i_vga_regs (
    .clk_i(clk_i), .rst_i(rst_i),
    .in_cyc_i(in_cyc_i), .in_stb_i(in_stb_i), .in_we_i(in_we_i),
    .in_adr_i(in_adr_i), .in_sel_i(in_sel_i), .in_dat_i(in_dat_i),
    .underrun_i(underrun), .pal_rdat_i(pal_rdat),
    .in_ack_o(in_ack_o), .in_stall_o(in_stall_o), .in_dat_o(in_dat_o),
    .base_o(base), .mode_o(mode),
    .pal_we_o(pal_we), .pal_widx_o(pal_widx), .pal_wdat_o(pal_wdat)
  );

  vga_fetch #(.DEPTH(FIFO_DEPTH)) i_vga_fetch (
    .clk_i(clk_i), .rst_i(rst_i),
    .base_i(base), .frame_start_i(frame_start), .pop_i(pop),
    .fb_ack_i(fb_ack_i), .fb_stall_i(fb_stall_i), .fb_dat_i(fb_dat_i),
    .fb_cyc_o(fb_cyc_o), .fb_stb_o(fb_stb_o), .fb_adr_o(fb_adr_o),
    .word_o(word), .empty_o(empty)
  );

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) i_vga_timing (
    .clk_i(clk_i), .rst_i(rst_i),
    .hs_o(t_hs), .vs_o(t_vs), .active_o(t_active), .frame_start_o(frame_start)
  );

  // register port reads back at the write index
  vga_palette i_vga_palette (
    .clk_i(clk_i),
    .we_i(pal_we), .widx_i(pal_widx), .wdat_i(pal_wdat),
    .ridx_i(pal_widx), .cidx_i(cidx),
    .rdat_o(pal_rdat), .cdat_o(cdat)
  );

  vga_pixel i_vga_pixel (
    .clk_i(clk_i), .rst_i(rst_i),
    .mode_i(mode), .active_i(t_active), .hs_i(t_hs), .vs_i(t_vs),
    .word_i(word), .empty_i(empty), .cdat_i(cdat),
    .pop_o(pop), .cidx_o(cidx), .underrun_o(underrun),
    .r_o(r_o), .g_o(g_o), .b_o(b_o),
    .hs_o(hs_o), .vs_o(vs_o), .blank_n_o(blank_n_o)
  );

endmodule

`default_nettype wire

//--- hw/vga_palette.sv
`timescale 1ns/1ps
`default_nettype none

module vga_palette (
  input  wire                clk_i,
  input  wire                we_i,
  input  wire [7:0]          widx_i,
  input  wire vga_pkg::rgb_t wdat_i,
  input  wire [7:0]          ridx_i,
  input  wire [7:0]          cidx_i,
  output vga_pkg::rgb_t      rdat_o,
  output vga_pkg::rgb_t      cdat_o
);

  import vga_pkg::*;

  rgb_t mem [256];

  always_ff @(posedge clk_i)
  begin
    if (we_i)
      mem[widx_i] <= wdat_i;
    rdat_o <= mem[ridx_i]; // register side, old data on a write
    cdat_o <= mem[cidx_i]; // colour lookup
  end

endmodule

`default_nettype wire

//--- hw/vga_pixel.sv
`timescale 1ns/1ps
`default_nettype none

module vga_pixel (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire vga_pkg::vga_mode_t mode_i,
  input  wire                     active_i,
  input  wire                     hs_i,
  input  wire                     vs_i,
  input  wire vga_pkg::wb_dat_t   word_i,
  input  wire                     empty_i,
  input  wire vga_pkg::rgb_t      cdat_i,
  output logic                    pop_o,
  output logic [7:0]              cidx_o,
  output logic                    underrun_o,
  output logic [7:0]              r_o,
  output logic [7:0]              g_o,
  output logic [7:0]              b_o,
  output logic                    hs_o,
  output logic                    vs_o,
  output logic                    blank_n_o
);

  import vga_pkg::*;

  logic [4:0] pix_q, pix_last;
  wb_dat_t    word_q, cur_word;
  logic       dead_q, need_word, starve;
  logic       act1_q, show1_q, hs1_q, vs1_q, bit1_q;
  logic [7:0] byte1_q;
  rgb_t       colour;

  assign pix_last  = (mode_i == MODE_MONO) ? 5'd31 : 5'd3;
  assign need_word = active_i && (pix_q == 5'd0) && !dead_q;
  assign starve    = need_word && empty_i;
  assign pop_o     = need_word && !empty_i;
  assign underrun_o = starve;

  // first pixel of a word comes straight from the FIFO head
  assign cur_word = (pix_q == 5'd0) ? word_i : word_q;
  assign cidx_o   = cur_word[8*pix_q[1:0] +: 8];

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      pix_q  <= '0;
      dead_q <= 1'b0;
    end
    else
    begin
      if (!vs_i)
        pix_q <= '0; // realign with the fetch each frame
      else if (active_i)
        pix_q <= (pix_q >= pix_last) ? 5'd0 : pix_q + 5'd1;
      if (!hs_i)
        dead_q <= 1'b0;
      else if (starve)
        dead_q <= 1'b1; // black until end of line
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop_o)
      word_q <= word_i;
    bit1_q  <= cur_word[pix_q];
    byte1_q <= cidx_o;
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      act1_q  <= 1'b0;
      show1_q <= 1'b0;
      hs1_q   <= 1'b1;
      vs1_q   <= 1'b1;
    end
    else
    begin
      act1_q  <= active_i;
      show1_q <= active_i && !dead_q && !starve;
      hs1_q   <= hs_i;
      vs1_q   <= vs_i;
    end
  end

  always_comb
  begin
    case (mode_i)
      MODE_MONO: colour = {24{bit1_q}};
      MODE_PAL:  colour = cdat_i; // lookup lands with stage 1
      MODE_GRAY: colour = {3{byte1_q}};
      default:   colour = '0;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      {r_o, g_o, b_o} <= '0;
      hs_o            <= 1'b1;
      vs_o            <= 1'b1;
      blank_n_o       <= 1'b0;
    end
    else
    begin
      {r_o, g_o, b_o} <= show1_q ? colour : '0;
      hs_o            <= hs1_q;
      vs_o            <= vs1_q;
      blank_n_o       <= act1_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/vga_pkg.sv
`default_nettype none

package vga_pkg;

  typedef logic [11:0] wb_adr_t; // register space, byte address
  typedef logic [31:0] wb_dat_t;
  typedef logic [3:0]  wb_sel_t;
  typedef logic [31:0] fb_adr_t; // frame buffer, word address

  // r in 23:16, g in 15:8, b in 7:0
  typedef logic [23:0] rgb_t;

  typedef enum logic [1:0] {
    MODE_MONO = 2'd0, // 1 bpp, white or black
    MODE_PAL  = 2'd1, // 8 bpp through the palette
    MODE_GRAY = 2'd2  // 8 bpp, r = g = b
  } vga_mode_t;

  localparam wb_adr_t REG_BASE   = 12'hc00;
  localparam wb_adr_t REG_MODE   = 12'hc04;
  localparam wb_adr_t REG_STATUS = 12'hc08; // bit 0 sticky underrun, write 1 clears

endpackage

`default_nettype wire

//--- hw/vga_regs.sv
`timescale 1ns/1ps
`default_nettype none

module vga_regs (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    in_cyc_i,
  input  wire                    in_stb_i,
  input  wire                    in_we_i,
  input  wire vga_pkg::wb_adr_t  in_adr_i,
  input  wire vga_pkg::wb_sel_t  in_sel_i,
  input  wire vga_pkg::wb_dat_t  in_dat_i,
  input  wire                    underrun_i,
  input  wire vga_pkg::rgb_t     pal_rdat_i,
  output logic                   in_ack_o,
  output logic                   in_stall_o,
  output vga_pkg::wb_dat_t       in_dat_o,
  output vga_pkg::fb_adr_t       base_o,
  output vga_pkg::vga_mode_t     mode_o,
  output logic                   pal_we_o,
  output logic [7:0]             pal_widx_o,
  output vga_pkg::rgb_t          pal_wdat_o
);

  import vga_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ACCESS, S_DONE} state_t;

  state_t    state_q;
  fb_adr_t   base_q;
  vga_mode_t mode_q;
  logic      underrun_q;
  logic      hit_pal, hit_base, hit_mode, hit_status;
  logic      wr_en;
  wb_dat_t   pal_merged;

  function automatic wb_dat_t merge_bytes(input wb_dat_t old_v, input wb_dat_t new_v,
                                          input wb_sel_t sel);
    wb_dat_t res;
    res = old_v;
    for (int i = 0; i < 4; i++)
      if (sel[i])
        res[8*i +: 8] = new_v[8*i +: 8];
    return res;
  endfunction

  assign hit_pal    = (in_adr_i[11:10] == 2'b00);
  assign hit_base   = (in_adr_i[11:2] == REG_BASE[11:2]);
  assign hit_mode   = (in_adr_i[11:2] == REG_MODE[11:2]);
  assign hit_status = (in_adr_i[11:2] == REG_STATUS[11:2]);

  assign in_ack_o   = (state_q == S_ACCESS);
  assign in_stall_o = 1'b0;
  assign wr_en      = (state_q == S_ACCESS) && in_we_i;

  // palette port is shared, old entry is back by the access cycle
  assign pal_widx_o = in_adr_i[9:2];
  assign pal_merged = merge_bytes({8'h00, pal_rdat_i}, in_dat_i, in_sel_i);
  assign pal_wdat_o = pal_merged[23:0];
  assign pal_we_o   = wr_en && hit_pal;

  assign base_o = base_q;
  assign mode_o = mode_q;

  always_comb
  begin
    in_dat_o = '0; // unmapped reads
    if (state_q == S_ACCESS && !in_we_i)
    begin
      if (hit_pal)
        in_dat_o = {8'h00, pal_rdat_i};
      else if (hit_base)
        in_dat_o = base_q;
      else if (hit_mode)
        in_dat_o = {30'h0, mode_q};
      else if (hit_status)
        in_dat_o = {31'h0, underrun_q};
    end
  end

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      state_q    <= S_IDLE;
      base_q     <= '0;
      mode_q     <= MODE_MONO;
      underrun_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        S_IDLE:
          if (in_cyc_i && in_stb_i)
            state_q <= S_ACCESS;
        S_ACCESS:
          state_q <= S_DONE;
        default:
          state_q <= S_IDLE;
      endcase
      if (wr_en && hit_base)
        base_q <= merge_bytes(base_q, in_dat_i, in_sel_i);
      if (wr_en && hit_mode && in_sel_i[0])
        mode_q <= vga_mode_t'(in_dat_i[1:0]);
      if (underrun_i)
        underrun_q <= 1'b1; // a new underrun beats the clear
      else if (wr_en && hit_status && in_sel_i[0] && in_dat_i[0])
        underrun_q <= 1'b0;
    end
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    in_ack_o |=> !in_ack_o);

endmodule

`default_nettype wire

//--- hw/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  wire  clk_i,
  input  wire  rst_i,
  output logic hs_o,
  output logic vs_o,
  output logic active_o,
  output logic frame_start_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HW = $clog2(H_TOTAL);
  localparam int VW = $clog2(V_TOTAL);

  logic [HW-1:0] hcnt_q;
  logic [VW-1:0] vcnt_q;
  logic          h_wrap;

  assign h_wrap = (hcnt_q == HW'(H_TOTAL - 1));

  always_ff @(posedge clk_i or posedge rst_i)
  begin
    if (rst_i)
    begin
      hcnt_q <= '0;
      vcnt_q <= VW'(V_ACTIVE); // come up in vertical blank so the FIFO can fill
    end
    else if (h_wrap)
    begin
      hcnt_q <= '0;
      vcnt_q <= (vcnt_q == VW'(V_TOTAL - 1)) ? '0 : vcnt_q + 1'b1;
    end
    else
      hcnt_q <= hcnt_q + 1'b1;
  end

  assign hs_o = !(hcnt_q >= HW'(H_ACTIVE + H_FRONT) &&
                  hcnt_q < HW'(H_ACTIVE + H_FRONT + H_SYNC));
  assign vs_o = !(vcnt_q >= VW'(V_ACTIVE + V_FRONT) &&
                  vcnt_q < VW'(V_ACTIVE + V_FRONT + V_SYNC));
  assign active_o = (hcnt_q < HW'(H_ACTIVE)) && (vcnt_q < VW'(V_ACTIVE));

  // last visible pixel, the fetch restarts and refills during vertical blank
  assign frame_start_o = (hcnt_q == HW'(H_ACTIVE - 1)) && (vcnt_q == VW'(V_ACTIVE - 1));

  a_hcnt_range: assert property (@(posedge clk_i) disable iff (rst_i)
    int'(hcnt_q) < H_TOTAL);

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_NS      = 2,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_o = 1'b0;
  end

  always #(HALF_NS) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- verif/tb_vga_master.sv
`timescale 1ns/1ps
`default_nettype none

// measures runs of one level of a signal, and the distance between run starts
module pulse_width_check #(
  parameter string NAME   = "sig",
  parameter bit    LEVEL  = 1'b0,
  parameter int    WIDTH  = 1,
  parameter int    PERIOD = 0 // 0 skips the period
) (
  input  wire clk_i,
  input  wire rst_i,
  input  wire sig_i,
  output int  errors_o,
  output int  pulses_o
);

  logic prev;
  bit   started;
  int   width, period;

  initial
  begin
    errors_o = 0;
    pulses_o = 0;
  end

  always @(negedge clk_i)
  begin
    if (rst_i)
    begin
      prev    = ~LEVEL;
      started = 1'b0;
    end
    else
    begin
      if (sig_i == LEVEL && prev != LEVEL)
      begin
        if (started && PERIOD != 0)
          assert (period == PERIOD)
          else
          begin
            errors_o++;
            $display("[ERROR] %0t %s period exp %0d got %0d", $time, NAME, PERIOD, period);
          end
        started = 1'b1;
        period  = 0;
        width   = 0;
      end
      if (sig_i != LEVEL && prev == LEVEL && started)
      begin
        pulses_o++;
        assert (width == WIDTH)
        else
        begin
          errors_o++;
          $display("[ERROR] %0t %s width exp %0d got %0d", $time, NAME, WIDTH, width);
        end
      end
      if (sig_i == LEVEL)
        width++;
      period++;
      prev = sig_i;
    end
  end

endmodule

module tb_vga_master;

  import vga_pkg::*;

  localparam int H_ACTIVE = 8, H_FRONT = 2, H_SYNC = 2, H_BACK = 2;
  localparam int V_ACTIVE = 4, V_FRONT = 1, V_SYNC = 1, V_BACK = 1;
  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME = H_TOTAL * V_TOTAL;
  localparam int TIMEOUT_NS = (40 * FRAME + 4000) * 4; // frames used plus palette load

  logic clk_i, rst_i;
  logic in_cyc_i, in_stb_i, in_we_i;
  wb_adr_t in_adr_i;
  wb_sel_t in_sel_i;
  wb_dat_t in_dat_i, in_dat_o;
  logic in_ack_o, in_stall_o;
  logic fb_cyc_o, fb_stb_o, fb_ack_i, fb_stall_i;
  fb_adr_t fb_adr_o;
  wb_dat_t fb_dat_i;
  logic [7:0] r_o, g_o, b_o;
  logic hs_o, vs_o, blank_n_o;
  logic stall_all;

  int err_regs, err_video, err_hs, err_vs, err_blank, n_hs, n_vs, n_blank;
  int pix_n, checked;
  bit video_chk;
  fb_adr_t base_model;
  vga_mode_t mode_model;
  rgb_t pal_model [256];

  tb_clock_gen #(.HALF_NS(2), .RESET_CYCLES(5)) i_clock_gen (.clk_o(clk_i), .rst_o(rst_i));

  vga_master #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .FIFO_DEPTH(8)
  ) i_vga_master (
    .clk_i(clk_i), .rst_i(rst_i),
    .in_cyc_i(in_cyc_i), .in_stb_i(in_stb_i), .in_we_i(in_we_i),
    .in_adr_i(in_adr_i), .in_sel_i(in_sel_i), .in_dat_i(in_dat_i),
    .in_ack_o(in_ack_o), .in_stall_o(in_stall_o), .in_dat_o(in_dat_o),
    .fb_cyc_o(fb_cyc_o), .fb_stb_o(fb_stb_o), .fb_adr_o(fb_adr_o),
    .fb_ack_i(fb_ack_i), .fb_stall_i(fb_stall_i), .fb_dat_i(fb_dat_i),
    .r_o(r_o), .g_o(g_o), .b_o(b_o), .hs_o(hs_o), .vs_o(vs_o), .blank_n_o(blank_n_o)
  );

  tb_wb_mem i_mem (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(fb_cyc_o), .stb_i(fb_stb_o), .adr_i(fb_adr_o),
    .stall_all_i(stall_all), .ack_o(fb_ack_i), .stall_o(fb_stall_i), .dat_o(fb_dat_i)
  );

  pulse_width_check #(.NAME("hs_o"), .LEVEL(1'b0), .WIDTH(H_SYNC), .PERIOD(H_TOTAL))
    i_hs_check (.clk_i(clk_i), .rst_i(rst_i), .sig_i(hs_o), .errors_o(err_hs), .pulses_o(n_hs));
  pulse_width_check #(.NAME("vs_o"), .LEVEL(1'b0), .WIDTH(V_SYNC * H_TOTAL), .PERIOD(FRAME))
    i_vs_check (.clk_i(clk_i), .rst_i(rst_i), .sig_i(vs_o), .errors_o(err_vs), .pulses_o(n_vs));
  pulse_width_check #(.NAME("blank_n_o"), .LEVEL(1'b1), .WIDTH(H_ACTIVE), .PERIOD(0))
    i_blank_check (.clk_i(clk_i), .rst_i(rst_i), .sig_i(blank_n_o), .errors_o(err_blank),
                   .pulses_o(n_blank));

  function automatic logic [31:0] fb_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ (a << 16) ^ 32'h0f1e2d3c;
  endfunction

  function automatic rgb_t pal_entry(input int i);
    return {8'(i) ^ 8'h3c, ~8'(i), 8'(i * 7)};
  endfunction

  // pixels run least significant first through consecutive words from base
  function automatic rgb_t expected_colour(input int p);
    logic [31:0] w;
    logic [7:0]  pix;
    w = fb_word(base_model + ((mode_model == MODE_MONO) ? p / 32 : p / 4));
    pix = w[8 * (p % 4) +: 8];
    case (mode_model)
      MODE_MONO: return w[p % 32] ? 24'hffffff : 24'h000000;
      MODE_PAL:  return pal_model[pix];
      default:   return {3{pix}};
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got, input bit video);
    $display("[ERROR] %0t %s exp %h got %h", $time, name, exp, got);
    if (video)
      err_video++;
    else
      err_regs++;
  endtask

  // called 1 ns after a rising edge, returns at the same point
  task automatic bus_access(input logic we, input wb_adr_t adr, input wb_sel_t sel,
                            input wb_dat_t wdat, output wb_dat_t rdat);
    int waited;
    waited   = 0;
    in_cyc_i = 1'b1;
    in_stb_i = 1'b1;
    in_we_i  = we;
    in_adr_i = adr;
    in_sel_i = sel;
    in_dat_i = wdat;
    while (waited < 8)
    begin
      @(posedge clk_i);
      waited++;
      @(negedge clk_i);
      if (in_ack_o)
        break;
    end
    rdat = in_dat_o;
    assert (in_ack_o)
    else
    begin
      $display("register access at %h got no ack within 8 cycles", adr);
      err_regs++;
    end
    assert (waited == 1) else report_mismatch("in_ack_o latency", 1, waited, 1'b0);
    assert (!in_stall_o) else report_mismatch("in_stall_o", 0, in_stall_o, 1'b0);
    @(posedge clk_i);
    #1;
    in_cyc_i = 1'b0;
    in_stb_i = 1'b0;
    in_we_i  = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic bus_write(input wb_adr_t adr, input wb_dat_t dat, input wb_sel_t sel);
    wb_dat_t unused;
    bus_access(1'b1, adr, sel, dat, unused);
  endtask

  task automatic check_read(input wb_adr_t adr, input wb_dat_t exp, input string name);
    wb_dat_t got;
    bus_access(1'b0, adr, 4'hf, '0, got);
    assert (got == exp) else report_mismatch({"in_dat_o, ", name}, exp, got, 1'b0);
  endtask

  task automatic wait_frames(input int n);
    repeat (n) @(negedge vs_o);
  endtask

  task automatic check_video_frames(input int n);
    int start;
    start = checked;
    video_chk = 1'b1;
    wait_frames(n);
    video_chk = 1'b0;
    assert (checked - start == n * H_ACTIVE * V_ACTIVE)
    else report_mismatch("visible pixel count", n * H_ACTIVE * V_ACTIVE, checked - start, 1'b1);
  endtask

  always @(negedge clk_i)
  begin
    if (!rst_i)
    begin
      if (!blank_n_o)
        assert ({r_o, g_o, b_o} == 24'h0)
        else report_mismatch("{r_o, g_o, b_o} while blank", 0, {r_o, g_o, b_o}, 1'b1);
      if (!vs_o)
        pix_n = 0;
      else if (blank_n_o)
      begin
        if (video_chk)
        begin
          assert ({r_o, g_o, b_o} == expected_colour(pix_n))
          else report_mismatch("{r_o, g_o, b_o}", expected_colour(pix_n), {r_o, g_o, b_o},
                               1'b1);
          checked++;
        end
        pix_n++;
      end
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the test sequence did not finish", TIMEOUT_NS);
    $display("Something failed");
    $finish;
  end

  initial
  begin
    in_cyc_i = 1'b0;
    in_stb_i = 1'b0;
    in_we_i  = 1'b0;
    in_adr_i = '0;
    in_sel_i = '0;
    in_dat_i = '0;
    stall_all = 1'b0;
    err_regs  = 0;
    err_video = 0;
    pix_n     = 0;
    checked   = 0;
    video_chk = 1'b0;
    base_model = '0;
    mode_model = MODE_MONO;
    @(negedge rst_i);
    @(posedge clk_i);
    #1;

    // register access with partial selects
    check_read(REG_MODE, 32'h0, "mode after reset");
    check_read(REG_BASE, 32'h0, "base after reset");
    bus_write(REG_BASE, 32'h12345678, 4'hf);
    bus_write(REG_BASE, 32'haabbccdd, 4'b0101);
    check_read(REG_BASE, 32'h12bb56dd, "base merged");
    bus_write(12'h014, 32'h00112233, 4'b0111);
    bus_write(12'h014, 32'h00ffeedd, 4'b0010);
    check_read(12'h014, 32'h0011ee33, "palette 5 merged");
    bus_write(REG_MODE, 32'h2, 4'b0001);
    check_read(REG_MODE, 32'h2, "mode");
    check_read(12'h800, 32'h0, "unmapped 0x800");
    check_read(12'hc10, 32'h0, "unmapped 0xc10");

    // grayscale
    bus_write(REG_BASE, 32'h100, 4'hf);
    base_model = 32'h100;
    mode_model = MODE_GRAY;
    wait_frames(2);
    check_video_frames(3);

    // palette
    for (int i = 0; i < 256; i++)
    begin
      bus_write(wb_adr_t'(i * 4), {8'h00, pal_entry(i)}, 4'b0111);
      pal_model[i] = pal_entry(i);
    end
    check_read(12'h3fc, {8'h00, pal_entry(255)}, "palette 255");
    bus_write(REG_MODE, 32'h1, 4'b0001);
    mode_model = MODE_PAL;
    wait_frames(2);
    check_video_frames(2);

    // mono
    bus_write(REG_MODE, 32'h0, 4'b0001);
    mode_model = MODE_MONO;
    wait_frames(2);
    check_video_frames(2);

    // underrun with the memory stalled, flag starts out clear
    bus_write(REG_STATUS, 32'h1, 4'b0001);
    check_read(REG_STATUS, 32'h0, "status before stall");
    stall_all = 1'b1;
    wait_frames(3);
    check_read(REG_STATUS, 32'h1, "status underrun");
    stall_all = 1'b0;
    wait_frames(3);
    bus_write(REG_STATUS, 32'h1, 4'b0001);
    check_read(REG_STATUS, 32'h0, "status cleared");

    assert (n_hs > 0 && n_vs > 0 && n_blank > 0)
    else
    begin
      $display("sync or blank pulses were never seen");
      err_regs++;
    end

    $display("errors: regs %0d, video %0d, hs %0d, vs %0d, blank %0d",
             err_regs, err_video, err_hs, err_vs, err_blank);
    if (err_regs + err_video + err_hs + err_vs + err_blank == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/tb_wb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_mem (
  input  wire        clk_i,
  input  wire        rst_i,
  input  wire        cyc_i,
  input  wire        stb_i,
  input  wire [31:0] adr_i,
  input  wire        stall_all_i, // hold stall high for the underrun test
  output logic       ack_o,
  output logic       stall_o,
  output logic [31:0] dat_o
);

  integer      seed;
  logic [31:0] pend [$];

  // frame buffer contents as a function of the word address
  function automatic logic [31:0] fb_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ (a << 16) ^ 32'h0f1e2d3c;
  endfunction

  initial
  begin
    seed    = 32'h62232263;
    ack_o   = 1'b0;
    stall_o = 1'b0;
    dat_o   = '0;
  end

  always @(posedge clk_i)
  begin
    if (ack_o)
      void'(pend.pop_front());
    if (cyc_i && stb_i && !stall_o)
      pend.push_back(adr_i);
    if (rst_i)
      pend.delete();
    #1;
    stall_o = stall_all_i || (($random(seed) & 3) == 0);
    if (pend.size() != 0 && (($random(seed) & 3) != 0))
    begin
      ack_o = 1'b1;
      dat_o = fb_word(pend[0]);
    end
    else
    begin
      ack_o = 1'b0;
      dat_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- vlog.f
hw/vga_pkg.sv
hw/vga_timing.sv
hw/vga_palette.sv
hw/vga_regs.sv
hw/vga_fetch.sv
hw/vga_pixel.sv
hw/vga_master.sv
verif/tb_clock_gen.sv
verif/tb_wb_mem.sv
verif/tb_vga_master.sv
